//--- backend.sv
`timescale 1ns/1ps

module backend (
	input  logic                  clk,
	input  logic                  reset_i,
	input  be_pkg::inst_t [1:0]   inst_i,
	input  logic [1:0]            inst_valid_i,
	output logic [1:0]            issue_num_o,  // 0, 1 or 2
	output logic                  backend_stall_o,
	output logic                  flush_o,
	output be_pkg::pc_t           flush_pc_o,
	output be_pkg::commit_t [1:0] commit_o
);
	import be_pkg::*;

	logic [1:0]         issue;
	logic               revert;
	logic [1:0]         pipe_issue;
	logic [1:0][2:0]    stall_req, clr_req, stall_vec, clr_vec;
	logic               any_clr;
	logic               rev_ex_q, rev_m1_q;  // revert of the pair in ex and m1
	stage_t [1:0]       stage;
	fwd_src_t [1:0][1:0] fwd_out;
	fwd_src_t [3:0]     fwd_bus;
	logic [1:0]         w_en;
	reg_idx_t [1:0]     w_addr;
	xlen_t [1:0]        w_data;
	reg_idx_t [3:0]     r_addr;
	xlen_t [3:0]        r_data;
	logic [1:0]         flush;
	pc_t [1:0]          flush_pc;

	assign any_clr = clr_vec[0][STAGE_EX] | clr_vec[0][STAGE_M1] |
		clr_vec[1][STAGE_EX] | clr_vec[1][STAGE_M1];

	issue issue_module (
		.inst_i       (inst_i),
		.inst_valid_i (inst_valid_i),
		.stall_i      (stall_vec[0][STAGE_EX]),  // no issue while ex is held
		.flush_i      (any_clr),
		.issue_o      (issue),
		.revert_o     (revert)
	);

	assign issue_num_o     = {issue[1], issue[0] & ~issue[1]};
	assign backend_stall_o = stall_vec[0][STAGE_EX];

	for (genvar p = 0; p < 2; p++) begin : g_pipe_sel
		inst_t sel;
		assign sel           = inst_i[(p == 0) ? revert : !revert];
		assign pipe_issue[p] = issue[(p == 0) ? revert : !revert];
		assign r_addr[2*p]   = sel.rs1;
		assign r_addr[2*p+1] = sel.rs2;
		assign stage[p] = '{valid: pipe_issue[p], inst: sel, a: r_data[2*p],
			b: r_data[2*p+1], result: '0, revert: revert};
		assign w_en[p]   = fwd_out[p][1].valid && commit_o[p].valid;
		assign w_addr[p] = commit_o[p].rd;
		assign w_data[p] = commit_o[p].data;
	end

	reg_file reg_file_module (
		.clk      (clk),
		.reset_i  (reset_i),
		.w_en_i   (w_en),
		.w_addr_i (w_addr),
		.w_data_i (w_data),
		.r_addr_i (r_addr),
		.r_data_o (r_data)
	);

	assign fwd_bus = {fwd_out[1], fwd_out[0]};

	always_ff @(posedge clk) begin
		if (reset_i) begin
			rev_ex_q <= 1'b0;
			rev_m1_q <= 1'b0;
		end else begin
			if (!stall_vec[0][STAGE_EX]) rev_ex_q <= revert;
			if (!stall_vec[0][STAGE_M1]) rev_m1_q <= rev_ex_q;
		end
	end

	pipe_ctrl pipe_ctrl_module (
		.stall_req_i (stall_req),
		.clr_req_i   (clr_req),
		.revert_m1_i (rev_m1_q),
		.stall_vec_o (stall_vec),
		.clr_vec_o   (clr_vec)
	);

	backend_pipeline #(.MAIN_PIPE(1'b1)) pipeline_0 (
		.clk         (clk),
		.reset_i     (reset_i),
		.issue_i     (pipe_issue[0]),
		.revert_i    (revert),
		.stage_i     (stage[0]),
		.fwd_i       (fwd_bus),
		.stall_i     (stall_vec[0]),
		.clr_i       (clr_vec[0]),
		.stall_req_o (stall_req[0]),
		.clr_req_o   (clr_req[0]),
		.fwd_o       (fwd_out[0]),
		.commit_o    (commit_o[0]),
		.flush_o     (flush[0]),
		.flush_pc_o  (flush_pc[0])
	);

	backend_pipeline #(.MAIN_PIPE(1'b0)) pipeline_1 (
		.clk         (clk),
		.reset_i     (reset_i),
		.issue_i     (pipe_issue[1]),
		.revert_i    (revert),
		.stage_i     (stage[1]),
		.fwd_i       (fwd_bus),
		.stall_i     (stall_vec[1]),
		.clr_i       (clr_vec[1]),
		.stall_req_o (stall_req[1]),
		.clr_req_o   (clr_req[1]),
		.fwd_o       (fwd_out[1]),
		.commit_o    (commit_o[1]),
		.flush_o     (flush[1]),
		.flush_pc_o  (flush_pc[1])
	);

	// front-end redirect
	assign flush_o    = |flush;
	assign flush_pc_o = flush[0] ? flush_pc[0] : flush_pc[1];

endmodule

//--- backend_pipeline.sv
`timescale 1ns/1ps

module backend_pipeline #(
	parameter bit MAIN_PIPE = 1'b0
) (
	input  logic                   clk,
	input  logic                   reset_i,
	input  logic                   issue_i,
	input  logic                   revert_i,
	input  be_pkg::stage_t         stage_i,
	input  be_pkg::fwd_src_t [3:0] fwd_i,  // p0 m1, p0 m2, p1 m1, p1 m2
	input  logic [2:0]             stall_i,
	input  logic [2:0]             clr_i,
	output logic [2:0]             stall_req_o,
	output logic [2:0]             clr_req_o,
	output be_pkg::fwd_src_t [1:0] fwd_o,  // m1, m2
	output be_pkg::commit_t        commit_o,
	output logic                   flush_o,
	output be_pkg::pc_t            flush_pc_o
);
	import be_pkg::*;

	stage_t   ex_q, m1_q, m2_q;
	stage_t   ex_res;
	logic     m2_shadow_q;  // older of a pair whose peer writes the same rd
	logic     shadow_d;
	fwd_src_t peer_m1;
	logic     mul_stall;
	logic     br_taken;

	// later hits override, so the newest source is checked last
	function automatic xlen_t fwd_pick(input reg_idx_t rs, input xlen_t cur,
			input fwd_src_t [3:0] src, input logic p0_young);
		xlen_t val;
		val = cur;
		if (src[3].valid && (src[3].rd == rs)) val = src[3].data;
		if (src[1].valid && (src[1].rd == rs)) val = src[1].data;
		if (p0_young) begin
			if (src[2].valid && (src[2].rd == rs)) val = src[2].data;
			if (src[0].valid && (src[0].rd == rs)) val = src[0].data;
		end else begin
			if (src[0].valid && (src[0].rd == rs)) val = src[0].data;
			if (src[2].valid && (src[2].rd == rs)) val = src[2].data;
		end
		return val;
	endfunction

	always_comb begin
		ex_res   = ex_q;
		ex_res.a = fwd_pick(ex_q.inst.rs1, ex_q.a, fwd_i, m1_q.revert);
		ex_res.b = fwd_pick(ex_q.inst.rs2, ex_q.b, fwd_i, m1_q.revert);
		case (ex_q.inst.op)
			OP_ADD:  ex_res.result = ex_res.a + ex_res.b;
			OP_SUB:  ex_res.result = ex_res.a - ex_res.b;
			OP_AND:  ex_res.result = ex_res.a & ex_res.b;
			OP_OR:   ex_res.result = ex_res.a | ex_res.b;
			OP_ADDI: ex_res.result = ex_res.a + ex_q.inst.imm;
			OP_MUL:  ex_res.result = MAIN_PIPE ? ex_res.a * ex_res.b : '0;
			default: ex_res.result = '0;  // beq writes no register
		endcase
	end

	if (MAIN_PIPE) begin : g_main
		logic [MUL_CNT_W-1:0] mul_cnt_q;

		always_ff @(posedge clk) begin
			if (reset_i || clr_i[STAGE_EX] || !stall_i[STAGE_EX]) begin
				mul_cnt_q <= '0;
			end else if (mul_stall) begin
				mul_cnt_q <= mul_cnt_q + 1'b1;
			end
		end

		assign mul_stall = ex_q.valid && (ex_q.inst.op == OP_MUL) &&
			(mul_cnt_q != MUL_CNT_W'(MUL_EXTRA));
		assign br_taken = m1_q.valid && (m1_q.inst.op == OP_BEQ) &&
			(m1_q.a == m1_q.b) && !stall_i[STAGE_M1];
		assign flush_pc_o = m1_q.inst.pc + m1_q.inst.imm;
	end else begin : g_alu
		assign mul_stall  = 1'b0;
		assign br_taken   = 1'b0;
		assign flush_pc_o = '0;
	end

	always_comb begin
		stall_req_o           = '0;
		stall_req_o[STAGE_EX] = mul_stall;
		clr_req_o             = '0;
		clr_req_o[STAGE_M1]   = br_taken;  // kill younger work
	end
	assign flush_o = br_taken;

	assign peer_m1  = MAIN_PIPE ? fwd_i[2] : fwd_i[0];
	assign shadow_d = m1_q.valid && (m1_q.revert != MAIN_PIPE) && peer_m1.valid &&
		(peer_m1.rd == m1_q.inst.rd);

	always_ff @(posedge clk) begin
		if (reset_i) begin
			ex_q.valid  <= 1'b0;
			m1_q.valid  <= 1'b0;
			m2_q.valid  <= 1'b0;
			m2_shadow_q <= 1'b0;
		end else begin
			if (!stall_i[STAGE_EX]) begin
				ex_q        <= stage_i;
				ex_q.valid  <= issue_i;
				ex_q.revert <= revert_i;
			end else if (clr_i[STAGE_EX]) begin
				ex_q.valid <= 1'b0;
			end else begin
				ex_q <= ex_res;  // held, operands keep tracking the bypass
			end

			if (!stall_i[STAGE_M1]) begin
				m1_q       <= ex_res;
				m1_q.valid <= ex_q.valid && !stall_i[STAGE_EX] && !clr_i[STAGE_EX];
			end else if (clr_i[STAGE_M1]) begin
				m1_q.valid <= 1'b0;
			end

			if (!stall_i[STAGE_M2]) begin
				m2_q        <= m1_q;
				m2_q.valid  <= m1_q.valid && !stall_i[STAGE_M1] && !clr_i[STAGE_M1];
				m2_shadow_q <= shadow_d;
			end else if (clr_i[STAGE_M2]) begin
				m2_q.valid <= 1'b0;
			end
		end
	end

	assign fwd_o[0] = '{valid: m1_q.valid && (m1_q.inst.rd != '0),
		rd: m1_q.inst.rd, data: m1_q.result};
	assign fwd_o[1] = '{valid: m2_q.valid && (m2_q.inst.rd != '0) && !m2_shadow_q,
		rd: m2_q.inst.rd, data: m2_q.result};

	assign commit_o = '{valid: m2_q.valid && !stall_i[STAGE_M2] && !clr_i[STAGE_M2],
		pc: m2_q.inst.pc, rd: m2_q.inst.rd, data: m2_q.result};

endmodule

//--- backend_properties.sv
`timescale 1ns/1ps

module backend_properties (
	input logic                  clk,
	input logic                  reset_i,
	input logic [1:0]            issue_num_i,
	input logic                  flush_i,
	input be_pkg::commit_t [1:0] commit_i
);
	int fail_cnt = 0;

	a_issue_max: assert property (@(posedge clk) disable iff (reset_i) issue_num_i <= 2'd2)
		else begin
			fail_cnt++;
			$error("issue count above two");
		end

	// redirect is a single-cycle pulse
	a_flush_pulse: assert property (@(posedge clk) disable iff (reset_i) flush_i |=> !flush_i)
		else begin
			fail_cnt++;
			$error("flush held for more than one cycle");
		end

	// stage valids are cleared by the first edge in reset
	a_no_commit_in_reset: assert property (@(posedge clk)
		reset_i ##1 reset_i |-> !(commit_i[0].valid || commit_i[1].valid))
		else begin
			fail_cnt++;
			$error("commit during reset");
		end

endmodule

bind backend backend_properties u_backend_props (
	.clk         (clk),
	.reset_i     (reset_i),
	.issue_num_i (issue_num_o),
	.flush_i     (flush_o),
	.commit_i    (commit_o)
);

//--- be_pkg.sv
package be_pkg;

	localparam int XLEN      = 32;
	localparam int REG_IDX_W = 5;
	localparam int NUM_REGS  = 32;  // 2**REG_IDX_W
	localparam int MUL_EXTRA = 2;   // extra ex cycles of a multiply
	localparam int MUL_CNT_W = $clog2(MUL_EXTRA + 1);

	// bit positions in the per-pipe stall and clear vectors
	localparam int STAGE_EX = 0;
	localparam int STAGE_M1 = 1;
	localparam int STAGE_M2 = 2;

	typedef logic [XLEN-1:0]      xlen_t;
	typedef logic [REG_IDX_W-1:0] reg_idx_t;
	typedef logic [XLEN-1:0]      pc_t;

	typedef enum logic [2:0] {
		OP_ADD  = 3'd0,
		OP_SUB  = 3'd1,
		OP_AND  = 3'd2,
		OP_OR   = 3'd3,
		OP_ADDI = 3'd4,
		OP_MUL  = 3'd5,  // main pipe only
		OP_BEQ  = 3'd6   // main pipe only, rd is zero
	} op_e;

	typedef struct packed {
		pc_t      pc;
		op_e      op;
		reg_idx_t rd;
		reg_idx_t rs1;
		reg_idx_t rs2;
		xlen_t    imm;  // addi immediate or branch offset
	} inst_t;

	typedef struct packed {
		logic     valid;
		reg_idx_t rd;
		xlen_t    data;
	} fwd_src_t;

	typedef struct packed {
		logic  valid;
		inst_t inst;
		xlen_t a;
		xlen_t b;
		xlen_t result;
		logic  revert;  // pair was swapped, pipe 0 holds the younger one
	} stage_t;

	typedef struct packed {
		logic     valid;
		pc_t      pc;
		reg_idx_t rd;
		xlen_t    data;
	} commit_t;

	function automatic logic is_main_op(op_e op);
		return (op == OP_MUL) || (op == OP_BEQ);
	endfunction

	// addi takes its second operand from imm
	function automatic logic reads_rs2(op_e op);
		return op != OP_ADDI;
	endfunction

endpackage

//--- issue.sv
`timescale 1ns/1ps

module issue (
	input  be_pkg::inst_t [1:0] inst_i,
	input  logic [1:0]          inst_valid_i,
	input  logic                stall_i,
	input  logic                flush_i,
	output logic [1:0]          issue_o,
	output logic                revert_o
);
	import be_pkg::*;

	logic [1:0] main_only;
	logic       rs1_hit;
	logic       rs2_hit;
	logic       raw_hazard;
	logic       class_clash;
	logic       pair_ok;

	always_comb begin
		for (int i = 0; i < 2; i++) begin
			main_only[i] = is_main_op(inst_i[i].op);
		end
	end

	// inst 1 reading what inst 0 writes, r0 never counts
	assign rs1_hit = inst_i[1].rs1 == inst_i[0].rd;
	assign rs2_hit = reads_rs2(inst_i[1].op) && (inst_i[1].rs2 == inst_i[0].rd);
	assign raw_hazard = (inst_i[0].rd != '0) && (rs1_hit || rs2_hit);

	// only one pipe has the multiplier and the branch unit
	assign class_clash = main_only[0] && main_only[1];

	assign pair_ok = inst_valid_i[1] && !raw_hazard && !class_clash;

	always_comb begin
		issue_o = 2'b00;
		if (!stall_i && !flush_i && inst_valid_i[0]) begin
			issue_o[0] = 1'b1;
			issue_o[1] = pair_ok;
		end
	end

	// simple ops of inst 0 go to pipe 1 so pipe 0 stays free for inst 1
	assign revert_o = (issue_o[1] && main_only[1]) || !main_only[0];

endmodule

//--- pipe_ctrl.sv
`timescale 1ns/1ps

module pipe_ctrl (
	input  logic [1:0][2:0] stall_req_i,
	input  logic [1:0][2:0] clr_req_i,
	input  logic            revert_m1_i,  // pair in m1 is swapped
	output logic [1:0][2:0] stall_vec_o,
	output logic [1:0][2:0] clr_vec_o
);
	import be_pkg::*;

	always_comb begin
		logic any_stall;
		logic any_clr;
		for (int lvl = 0; lvl < 3; lvl++) begin
			any_stall = 1'b0;
			any_clr   = 1'b0;
			// a stall holds its own stage and everything behind it
			for (int k = lvl; k < 3; k++) begin
				any_stall = any_stall | stall_req_i[0][k] | stall_req_i[1][k];
			end
			// a clear kills only the stages behind it
			for (int k = lvl + 1; k < 3; k++) begin
				any_clr = any_clr | clr_req_i[0][k] | clr_req_i[1][k];
			end
			stall_vec_o[0][lvl] = any_stall;
			stall_vec_o[1][lvl] = any_stall;
			clr_vec_o[0][lvl]   = any_clr;
			clr_vec_o[1][lvl]   = any_clr;
		end

		// same-stage peer dies only when it is the younger one
		clr_vec_o[1][STAGE_M1] = clr_vec_o[1][STAGE_M1] |
			(clr_req_i[0][STAGE_M1] & ~revert_m1_i);
		clr_vec_o[0][STAGE_M1] = clr_vec_o[0][STAGE_M1] |
			(clr_req_i[1][STAGE_M1] & revert_m1_i);
	end

endmodule

//--- reg_file.sv
`timescale 1ns/1ps

module reg_file (
	input  logic                   clk,
	input  logic                   reset_i,
	input  logic [1:0]             w_en_i,
	input  be_pkg::reg_idx_t [1:0] w_addr_i,
	input  be_pkg::xlen_t [1:0]    w_data_i,
	input  be_pkg::reg_idx_t [3:0] r_addr_i,
	output be_pkg::xlen_t [3:0]    r_data_o
);
	import be_pkg::*;

	xlen_t regs [NUM_REGS];

	always_ff @(posedge clk) begin
		if (reset_i) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else begin
			for (int w = 0; w < 2; w++) begin
				if (w_en_i[w] && (w_addr_i[w] != '0)) begin
					regs[w_addr_i[w]] <= w_data_i[w];  // port 1 last, so it wins
				end
			end
		end
	end

	// same-cycle write bypass
	always_comb begin
		for (int r = 0; r < 4; r++) begin
			r_data_o[r] = regs[r_addr_i[r]];
			for (int w = 0; w < 2; w++) begin
				if (w_en_i[w] && (w_addr_i[w] == r_addr_i[r])) begin
					r_data_o[r] = w_data_i[w];
				end
			end
			if (r_addr_i[r] == '0) begin
				r_data_o[r] = '0;
			end
		end
	end

endmodule

//--- tb_backend.sv
`timescale 1ns/1ps

module tb_backend;
	import be_pkg::*;

	localparam int NUM_TESTS  = 5;
	localparam int MAX_CYCLES = NUM_TESTS * 400;  // each test drains in well under 400 cycles

	logic          clk;
	logic          reset_i;
	inst_t [1:0]   inst_i;
	logic [1:0]    inst_valid_i;
	logic [1:0]    issue_num_o;
	logic          backend_stall_o;
	logic          flush_o;
	pc_t           flush_pc_o;
	commit_t [1:0] commit_o;

	inst_t       prog[$];        // program of the current test at pc 4 * index
	commit_t     exp_commit[$];  // retire order from the reference model
	pc_t         exp_flush[$];
	xlen_t       ref_regs [NUM_REGS];
	int          fe_idx;         // front end fetch pointer
	int          pair_cnt;
	int          stall_cnt;
	int          errors;
	int          checks;
	int          cycles;
	logic [31:0] rng_state = 32'h8df6_b879;

	backend u_backend (
		.clk             (clk),
		.reset_i         (reset_i),
		.inst_i          (inst_i),
		.inst_valid_i    (inst_valid_i),
		.issue_num_o     (issue_num_o),
		.backend_stall_o (backend_stall_o),
		.flush_o         (flush_o),
		.flush_pc_o      (flush_pc_o),
		.commit_o        (commit_o)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	function automatic logic [31:0] xorshift32();
		logic [31:0] x;
		x = rng_state;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		rng_state = x;
		return x;
	endfunction

	task automatic add_inst(input op_e op, input int rd, input int rs1, input int rs2,
			input xlen_t imm);
		inst_t ins;
		ins.pc  = pc_t'(prog.size() * 4);
		ins.op  = op;
		ins.rd  = reg_idx_t'(rd);
		ins.rs1 = reg_idx_t'(rs1);
		ins.rs2 = reg_idx_t'(rs2);
		ins.imm = imm;
		prog.push_back(ins);
	endtask

	// in-order reference execution that skips the shadow of taken branches
	task automatic predict();
		int      idx;
		inst_t   ins;
		xlen_t   a;
		xlen_t   b;
		xlen_t   res;
		commit_t c;
		idx = 0;
		while (idx < prog.size()) begin
			ins = prog[idx];
			a   = ref_regs[ins.rs1];
			b   = ref_regs[ins.rs2];
			idx++;
			case (ins.op)
				OP_ADD:  res = a + b;
				OP_SUB:  res = a - b;
				OP_AND:  res = a & b;
				OP_OR:   res = a | b;
				OP_ADDI: res = a + ins.imm;
				OP_MUL:  res = a * b;
				default: begin
					res = '0;
					if (a == b) begin  // taken beq
						exp_flush.push_back(ins.pc + ins.imm);
						idx = int'((ins.pc + ins.imm) >> 2);
					end
				end
			endcase
			c = '{valid: 1'b1, pc: ins.pc, rd: ins.rd, data: res};
			exp_commit.push_back(c);
			if (ins.rd != '0) ref_regs[ins.rd] = res;
		end
	endtask

	// front end offers the two oldest unissued instructions
	task automatic drive_offer();
		for (int k = 0; k < 2; k++) begin
			inst_valid_i[k] = (fe_idx + k) < prog.size();
			inst_i[k]       = inst_valid_i[k] ? prog[fe_idx + k] : '0;
		end
	endtask

	task automatic compare_commits();
		commit_t got[$];
		commit_t exp;
		if (commit_o[0].valid) got.push_back(commit_o[0]);
		if (commit_o[1].valid) got.push_back(commit_o[1]);
		if (got.size() == 2 && got[1].pc < got[0].pc) got.reverse();  // older first
		foreach (got[k]) begin
			checks++;
			assert (exp_commit.size() > 0) else begin
				errors++;
				$display("extra commit of pc %h at %0t after the program retired",
					got[k].pc, $time);
			end
			if (exp_commit.size() > 0) begin
				exp = exp_commit.pop_front();
				assert (got[k].pc == exp.pc && got[k].rd == exp.rd &&
						(exp.rd == '0 || got[k].data == exp.data)) else begin
					errors++;
					$display("error at %0t: got pc %h rd %0d data %h, want pc %h rd %0d data %h",
						$time, got[k].pc, got[k].rd, got[k].data, exp.pc, exp.rd, exp.data);
				end
			end
		end
	endtask

	task automatic match_flush_target();
		pc_t target;
		checks++;
		assert (exp_flush.size() > 0) else begin
			errors++;
			$display("flush to %h at %0t with no taken branch pending", flush_pc_o, $time);
		end
		if (exp_flush.size() > 0) begin
			target = exp_flush.pop_front();
			assert (flush_pc_o == target) else begin
				errors++;
				$display("error at %0t: flush to %h, expected %h", $time, flush_pc_o, target);
			end
		end
	endtask

	task automatic run_program(input int exp_pairs, input int exp_stalls);
		int   idle;
		int   n;
		logic redirect;
		pc_t  target;
		predict();
		pair_cnt  = 0;
		stall_cnt = 0;
		fe_idx    = 0;
		idle      = 0;
		drive_offer();
		while (idle < 6) begin  // a few quiet cycles catch stray commits
			@(negedge clk);
			compare_commits();
			if (flush_o) match_flush_target();
			redirect = flush_o;
			target   = flush_pc_o;
			n        = issue_num_o;
			if (backend_stall_o) stall_cnt++;
			if (issue_num_o == 2'd2) pair_cnt++;
			if (exp_commit.size() == 0 && fe_idx >= prog.size()) idle++;
			@(posedge clk);
			#1;
			fe_idx = redirect ? int'(target >> 2) : fe_idx + n;
			drive_offer();
		end
		checks += 3;
		assert (pair_cnt == exp_pairs) else begin
			errors++;
			$display("error at %0t: %0d dual issues, expected %0d", $time, pair_cnt, exp_pairs);
		end
		assert (stall_cnt == exp_stalls) else begin
			errors++;
			$display("error at %0t: %0d stall cycles, expected %0d", $time, stall_cnt, exp_stalls);
		end
		assert (exp_flush.size() == 0) else begin
			errors++;
			$display("%0d expected flushes never happened", exp_flush.size());
			exp_flush.delete();
		end
		for (int r = 0; r < NUM_REGS; r++) begin
			checks++;
			assert (u_backend.reg_file_module.regs[r] == ref_regs[r]) else begin
				errors++;
				$display("error at %0t: x%0d is %h, expected %h", $time, r,
					u_backend.reg_file_module.regs[r], ref_regs[r]);
			end
		end
	endtask

	task automatic independent_pairs();
		prog.delete();
		for (int r = 1; r <= 8; r++) add_inst(OP_ADDI, r, 0, 0, xorshift32());
		add_inst(OP_ADD, 9, 1, 2, '0);
		add_inst(OP_SUB, 10, 3, 4, '0);
		add_inst(OP_AND, 11, 5, 6, '0);
		add_inst(OP_OR, 12, 7, 8, '0);
		run_program(6, 0);
	endtask

	// each op reads the one before it and older values through m2 and the regfile
	task automatic dependent_chain();
		prog.delete();
		add_inst(OP_ADDI, 1, 0, 0, 32'd5);
		add_inst(OP_ADDI, 2, 1, 0, 32'd3);
		add_inst(OP_ADD, 3, 2, 1, '0);
		add_inst(OP_ADD, 4, 3, 3, '0);
		add_inst(OP_SUB, 5, 4, 1, '0);
		add_inst(OP_OR, 6, 5, 2, '0);
		add_inst(OP_AND, 7, 6, 4, '0);
		add_inst(OP_ADDI, 8, 7, 0, xlen_t'(-1));
		add_inst(OP_ADD, 9, 8, 6, '0);
		run_program(0, 0);
	endtask

	task automatic zero_register();
		prog.delete();
		add_inst(OP_ADDI, 0, 0, 0, 32'd55);
		add_inst(OP_ADD, 0, 1, 1, '0);
		add_inst(OP_ADD, 13, 0, 0, '0);
		add_inst(OP_ADDI, 14, 0, 0, 32'd9);
		add_inst(OP_OR, 15, 0, 14, '0);
		run_program(2, 0);
	endtask

	task automatic multiply_stall();
		prog.delete();
		add_inst(OP_ADDI, 16, 0, 0, xorshift32());
		add_inst(OP_MUL, 17, 16, 15, '0);
		add_inst(OP_ADD, 18, 17, 16, '0);
		add_inst(OP_MUL, 19, 16, 16, '0);   // swapped pair with the add held in pipe 1
		add_inst(OP_ADDI, 20, 0, 0, 32'd3);
		add_inst(OP_ADDI, 21, 0, 0, 32'd4);
		add_inst(OP_MUL, 22, 16, 14, '0);   // two muls never pair
		add_inst(OP_MUL, 23, 16, 21, '0);
		add_inst(OP_MUL, 24, 14, 23, '0);
		add_inst(OP_ADD, 12, 24, 22, '0);
		run_program(2, 5 * MUL_EXTRA);
	endtask

	task automatic branch_flush();
		prog.delete();
		add_inst(OP_ADDI, 25, 0, 0, 32'd1);
		add_inst(OP_ADDI, 26, 0, 0, 32'd1);
		add_inst(OP_BEQ, 0, 25, 26, 32'd12);  // taken as the older of its pair
		add_inst(OP_ADDI, 27, 0, 0, 32'd99);
		add_inst(OP_ADDI, 28, 0, 0, 32'd77);
		add_inst(OP_ADDI, 29, 0, 0, 32'd5);
		add_inst(OP_ADD, 30, 29, 25, '0);
		add_inst(OP_BEQ, 0, 25, 29, 32'd8);   // not taken
		add_inst(OP_ADDI, 31, 0, 0, 32'd8);
		add_inst(OP_BEQ, 0, 0, 0, 32'd8);     // taken as the younger of its pair
		add_inst(OP_ADDI, 2, 0, 0, 32'd66);
		add_inst(OP_OR, 3, 31, 25, '0);
		run_program(6, 0);
	endtask

	initial begin
		errors       = 0;
		checks       = 0;
		fe_idx       = 0;
		reset_i      = 1'b1;
		inst_i       = '0;
		inst_valid_i = '0;
		foreach (ref_regs[r]) ref_regs[r] = '0;
		repeat (8) @(posedge clk);
		#1;
		reset_i = 1'b0;
		independent_pairs();
		dependent_chain();
		zero_register();
		multiply_stall();
		branch_flush();
		$display("checks %0d, errors %0d, property failures %0d", checks, errors,
			u_backend.u_backend_props.fail_cnt);
		if (errors == 0 && u_backend.u_backend_props.fail_cnt == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

	initial begin : watchdog
		cycles = 0;
		while (cycles < MAX_CYCLES) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout: run still busy after %0d cycles", MAX_CYCLES);
		$display("tests failed");
		$finish;
	end

endmodule

//--- vlog.f
be_pkg.sv
issue.sv
reg_file.sv
backend_pipeline.sv
pipe_ctrl.sv
backend.sv
backend_properties.sv
tb_backend.sv
